// File: memAlignPkg.sv
package memAlignPkg;

    // line and page geometry
    localparam int LINE_BYTES = 16;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int PAGE_OFFSET_BITS = 12;

    // translation
    localparam int TLB_ENTRIES = 8;
    localparam int TLB_INDEX_BITS = $clog2(TLB_ENTRIES);
    localparam int FRAME_BITS = 3;
    localparam int VPN_BITS = 20;

    // frame plus line index within the page
    localparam int LINE_ADDR_BITS = FRAME_BITS + PAGE_OFFSET_BITS - LINE_OFFSET_BITS;
    localparam int TAG_BITS = 4;

    typedef enum logic [1:0] {
        size1,
        size2,
        size4,
        size8
    } sizeCode_e;

    typedef enum logic [1:0] {
        idle,
        firstLine,
        secondLine
    } accessState_e;

    typedef enum logic [1:0] {
        tlbMiss,
        writeProtect
    } faultCause_e;

    // incoming load/store with its data in the low bytes
    typedef struct packed {
        logic [31:0] vAddr;
        logic [63:0] data;
        sizeCode_e   size;
        logic        write;
    } memReq_t;

    typedef struct packed {
        logic                  valid;
        logic                  writable;
        logic [VPN_BITS-1:0]   vpn;
        logic [FRAME_BITS-1:0] frame;
    } tlbEntry_t;

    typedef struct packed {
        logic                  hit;
        logic                  writable;
        logic [FRAME_BITS-1:0] frame;
    } tlbResult_t;

    // one request towards the data cache
    typedef struct packed {
        logic [LINE_ADDR_BITS-1:0] lineAddr;
        logic [LINE_BYTES*8-1:0]   data;
        logic [LINE_BYTES-1:0]     byteMask;
        logic                      write;
        logic [TAG_BITS-1:0]       tag;
    } lineReq_t;

    typedef struct packed {
        faultCause_e         cause;
        logic [31:0]         vAddr;
        logic [TAG_BITS-1:0] tag;
    } faultReport_t;

endpackage

// File: tlbLookup.sv
module tlbLookup (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      tlbWrite,
    input  logic [memAlignPkg::TLB_INDEX_BITS-1:0]    tlbIndex,
    input  memAlignPkg::tlbEntry_t                    tlbEntry,
    input  logic [31:0]                               vAddr0,
    input  logic [31:0]                               vAddr1,
    output memAlignPkg::tlbResult_t                   result0,
    output memAlignPkg::tlbResult_t                   result1
);

    memAlignPkg::tlbEntry_t entries [memAlignPkg::TLB_ENTRIES];

    // fully associative search over all valid entries
    function automatic memAlignPkg::tlbResult_t lookup(input logic [31:0] vAddr);
        memAlignPkg::tlbResult_t res;
        logic [memAlignPkg::VPN_BITS-1:0] vpn;
        res = '0;
        vpn = vAddr[memAlignPkg::PAGE_OFFSET_BITS +: memAlignPkg::VPN_BITS];
        for (int i = 0; i < memAlignPkg::TLB_ENTRIES; i++) begin
            if (entries[i].valid && entries[i].vpn == vpn) begin
                res.hit = 1'b1;
                res.writable = entries[i].writable;
                res.frame = entries[i].frame;
            end
        end
        return res;
    endfunction

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < memAlignPkg::TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (tlbWrite) begin
            entries[tlbIndex] <= tlbEntry;
        end
    end

    // port 0 looks up the first line and port 1 the next one
    always_comb begin
        result0 = lookup(vAddr0);
        result1 = lookup(vAddr1);
    end

endmodule

// File: lineSplitter.sv
module lineSplitter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  memAlignPkg::memReq_t                req,
    input  memAlignPkg::tlbResult_t             result0,
    input  memAlignPkg::tlbResult_t             result1,
    input  logic [memAlignPkg::TAG_BITS-1:0]    tag,
    input  logic                                useSecond,
    output logic [31:0]                         vAddr0,
    output logic [31:0]                         vAddr1,
    output logic                                needSecond,
    output logic                                isWrite,
    output memAlignPkg::lineReq_t               line
);

    memAlignPkg::memReq_t reqReg;

    logic [memAlignPkg::LINE_OFFSET_BITS-1:0] offset;
    logic [4:0]                               byteCount;
    logic [4:0]                               endSum;
    logic [15:0]                              baseMask;
    logic [2*memAlignPkg::LINE_BYTES-1:0]     maskWide;
    logic [2*memAlignPkg::LINE_BYTES*8-1:0]   dataWide;
    memAlignPkg::tlbResult_t                  selResult;
    logic [31:0]                              selAddr;

    // request register, loaded when the FSM accepts a strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reqReg.vAddr <= '0;
            reqReg.size <= memAlignPkg::size1;
            reqReg.write <= 1'b0;
        end else if (load) begin
            reqReg <= req;
        end
    end

    always_comb begin
        case (reqReg.size)
            memAlignPkg::size1: byteCount = 5'd1;
            memAlignPkg::size2: byteCount = 5'd2;
            memAlignPkg::size4: byteCount = 5'd4;
            default:            byteCount = 5'd8;
        endcase
    end

    assign offset = reqReg.vAddr[memAlignPkg::LINE_OFFSET_BITS-1:0];
    assign endSum = {1'b0, offset} + byteCount;
    assign needSecond = endSum > 5'(memAlignPkg::LINE_BYTES);
    assign isWrite = reqReg.write;

    assign vAddr0 = reqReg.vAddr;
    // next line base with the offset bits cleared
    assign vAddr1 = (reqReg.vAddr & ~32'(memAlignPkg::LINE_BYTES - 1))
                  + 32'(memAlignPkg::LINE_BYTES);

    // shift across two lines at once
    // the upper half is what spills into the second line
    assign baseMask = (16'd1 << byteCount) - 16'd1;
    assign maskWide = {16'd0, baseMask} << offset;
    assign dataWide = {192'd0, reqReg.data} << {offset, 3'b000};

    always_comb begin
        selResult = useSecond ? result1 : result0;
        selAddr = useSecond ? vAddr1 : vAddr0;

        line.lineAddr = {selResult.frame,
                         selAddr[memAlignPkg::PAGE_OFFSET_BITS-1:memAlignPkg::LINE_OFFSET_BITS]};
        if (useSecond) begin
            line.data = dataWide[2*memAlignPkg::LINE_BYTES*8-1:memAlignPkg::LINE_BYTES*8];
            line.byteMask = maskWide[2*memAlignPkg::LINE_BYTES-1:memAlignPkg::LINE_BYTES];
        end else begin
            line.data = dataWide[memAlignPkg::LINE_BYTES*8-1:0];
            line.byteMask = maskWide[memAlignPkg::LINE_BYTES-1:0];
        end
        line.write = reqReg.write;
        line.tag = tag;
    end

endmodule

// File: accessFsm.sv
module accessFsm (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reqValid,
    input  logic                                needSecond,
    input  logic                                isWrite,
    input  memAlignPkg::tlbResult_t             result0,
    input  memAlignPkg::tlbResult_t             result1,
    input  logic [31:0]                         vAddr0,
    input  logic [31:0]                         vAddr1,
    input  logic [memAlignPkg::TAG_BITS-1:0]    tag,
    output logic                                load,
    output logic                                useSecond,
    output logic                                advance,
    output logic                                busy,
    output logic                                lineValid,
    output logic                                faultValid,
    output memAlignPkg::faultReport_t           fault
);

    memAlignPkg::accessState_e state;
    memAlignPkg::accessState_e nextState;

    logic faultDet;

    // strobes while busy fall on the floor
    assign load = (state == memAlignPkg::idle) && reqValid;

    // misses first, then write protection; port 0 before port 1
    always_comb begin
        faultDet = 1'b1;
        fault.cause = memAlignPkg::tlbMiss;
        fault.vAddr = vAddr0;
        fault.tag = tag;
        if (!result0.hit) begin
            fault.cause = memAlignPkg::tlbMiss;
        end else if (needSecond && !result1.hit) begin
            fault.cause = memAlignPkg::tlbMiss;
            fault.vAddr = vAddr1;
        end else if (isWrite && !result0.writable) begin
            fault.cause = memAlignPkg::writeProtect;
        end else if (needSecond && isWrite && !result1.writable) begin
            fault.cause = memAlignPkg::writeProtect;
            fault.vAddr = vAddr1;
        end else begin
            faultDet = 1'b0;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            memAlignPkg::idle: begin
                if (reqValid) begin
                    nextState = memAlignPkg::firstLine;
                end
            end
            memAlignPkg::firstLine: begin
                if (!faultDet && needSecond) begin
                    nextState = memAlignPkg::secondLine;
                end else begin
                    nextState = memAlignPkg::idle;
                end
            end
            default: begin
                nextState = memAlignPkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memAlignPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // fault decision only counts in the first cycle
    assign faultValid = (state == memAlignPkg::firstLine) && faultDet;
    assign lineValid = ((state == memAlignPkg::firstLine) && !faultDet)
                     || (state == memAlignPkg::secondLine);
    assign useSecond = state == memAlignPkg::secondLine;
    assign advance = lineValid;
    assign busy = state != memAlignPkg::idle;

endmodule

// File: requestTagCounter.sv
module requestTagCounter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                advance,
    output logic [memAlignPkg::TAG_BITS-1:0]    tag
);

    logic [memAlignPkg::TAG_BITS-1:0] count;

    // wraps naturally at the top of the tag range
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (advance) begin
            count <= count + 1'b1;
        end
    end

    assign tag = count;

endmodule

// File: memAlignTop.sv
module memAlignTop (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    reqValid,
    input  memAlignPkg::memReq_t                    req,
    input  logic                                    tlbWrite,
    input  logic [memAlignPkg::TLB_INDEX_BITS-1:0]  tlbIndex,
    input  memAlignPkg::tlbEntry_t                  tlbEntry,
    output logic                                    busy,
    output logic                                    lineValid,
    output memAlignPkg::lineReq_t                   lineOut,
    output logic                                    faultValid,
    output memAlignPkg::faultReport_t               fault
);

    logic                             load;
    logic                             useSecond;
    logic                             advance;
    logic                             needSecond;
    logic                             isWrite;
    logic [31:0]                      vAddr0;
    logic [31:0]                      vAddr1;
    logic [memAlignPkg::TAG_BITS-1:0] tag;
    memAlignPkg::tlbResult_t          result0;
    memAlignPkg::tlbResult_t          result1;

    tlbLookup tlbLookup_inst (
        .clk      (clk),
        .rst      (rst),
        .tlbWrite (tlbWrite),
        .tlbIndex (tlbIndex),
        .tlbEntry (tlbEntry),
        .vAddr0   (vAddr0),
        .vAddr1   (vAddr1),
        .result0  (result0),
        .result1  (result1)
    );

    lineSplitter lineSplitter_inst (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .req        (req),
        .result0    (result0),
        .result1    (result1),
        .tag        (tag),
        .useSecond  (useSecond),
        .vAddr0     (vAddr0),
        .vAddr1     (vAddr1),
        .needSecond (needSecond),
        .isWrite    (isWrite),
        .line       (lineOut)
    );

    accessFsm accessFsm_inst (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .needSecond (needSecond),
        .isWrite    (isWrite),
        .result0    (result0),
        .result1    (result1),
        .vAddr0     (vAddr0),
        .vAddr1     (vAddr1),
        .tag        (tag),
        .load       (load),
        .useSecond  (useSecond),
        .advance    (advance),
        .busy       (busy),
        .lineValid  (lineValid),
        .faultValid (faultValid),
        .fault      (fault)
    );

    requestTagCounter requestTagCounter_inst (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .tag     (tag)
    );

endmodule

// File: memAlignTb.sv
module memAlignTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int directedReqs = 7;
    localparam int randomReqs = 200;
    localparam int cycleLimit = 40 * (directedReqs + randomReqs) + 100;
    localparam bit kindLine = 1'b0;
    localparam bit kindFault = 1'b1;

    logic                                   clk;
    logic                                   rst;
    logic                                   reqValid;
    memAlignPkg::memReq_t                   req;
    logic                                   tlbWrite;
    logic [memAlignPkg::TLB_INDEX_BITS-1:0] tlbIndex;
    memAlignPkg::tlbEntry_t                 tlbEntry;
    logic                                   busy;
    logic                                   lineValid;
    memAlignPkg::lineReq_t                  lineOut;
    logic                                   faultValid;
    memAlignPkg::faultReport_t              fault;

    // shadow of what has been written into the TLB
    memAlignPkg::tlbEntry_t [memAlignPkg::TLB_ENTRIES-1:0] shadowTlb;
    logic [memAlignPkg::TAG_BITS-1:0] tbTag;
    int seed;
    int cycleCount;

    bit                        expKind[$];
    memAlignPkg::lineReq_t     expLines[$];
    memAlignPkg::faultReport_t expFaults[$];

    memAlignTop memAlignTop_inst (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .req        (req),
        .tlbWrite   (tlbWrite),
        .tlbIndex   (tlbIndex),
        .tlbEntry   (tlbEntry),
        .busy       (busy),
        .lineValid  (lineValid),
        .lineOut    (lineOut),
        .faultValid (faultValid),
        .fault      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkLine(input memAlignPkg::lineReq_t expL, input memAlignPkg::lineReq_t actL);
        string name;
        logic [127:0] e;
        logic [127:0] a;
        bit bad;
        bad = 1'b1;
        name = "";
        e = '0;
        a = '0;
        if (actL.lineAddr !== expL.lineAddr) begin
            name = "lineOut.lineAddr";
            e = 128'(expL.lineAddr);
            a = 128'(actL.lineAddr);
        end else if (actL.data !== expL.data) begin
            name = "lineOut.data";
            e = expL.data;
            a = actL.data;
        end else if (actL.byteMask !== expL.byteMask) begin
            name = "lineOut.byteMask";
            e = 128'(expL.byteMask);
            a = 128'(actL.byteMask);
        end else if (actL.write !== expL.write) begin
            name = "lineOut.write";
            e = 128'(expL.write);
            a = 128'(actL.write);
        end else if (actL.tag !== expL.tag) begin
            name = "lineOut.tag";
            e = 128'(expL.tag);
            a = 128'(actL.tag);
        end else begin
            bad = 1'b0;
        end
        if (bad) begin
            $display("FAIL %s expected %h got %h", name, e, a);
            $display("TEST FAILED");
            $fatal(1, "line mismatch");
        end
    endtask

    task automatic checkFault(input memAlignPkg::faultReport_t expF,
                              input memAlignPkg::faultReport_t actF);
        string name;
        logic [31:0] e;
        logic [31:0] a;
        bit bad;
        bad = 1'b1;
        name = "";
        e = '0;
        a = '0;
        if (actF.cause !== expF.cause) begin
            name = "fault.cause";
            e = 32'(expF.cause);
            a = 32'(actF.cause);
        end else if (actF.vAddr !== expF.vAddr) begin
            name = "fault.vAddr";
            e = expF.vAddr;
            a = actF.vAddr;
        end else if (actF.tag !== expF.tag) begin
            name = "fault.tag";
            e = 32'(expF.tag);
            a = 32'(actF.tag);
        end else begin
            bad = 1'b0;
        end
        if (bad) begin
            $display("FAIL %s expected %h got %h", name, e, a);
            $display("TEST FAILED");
            $fatal(1, "fault mismatch");
        end
    endtask

    // number of lines to expect, or 0 for a fault
    function automatic int refModel(
        input  memAlignPkg::memReq_t                                  r,
        input  memAlignPkg::tlbEntry_t [memAlignPkg::TLB_ENTRIES-1:0] tlb,
        input  logic [memAlignPkg::TAG_BITS-1:0]                      tagIn,
        output memAlignPkg::lineReq_t                                 l0,
        output memAlignPkg::lineReq_t                                 l1,
        output memAlignPkg::faultReport_t                             f
    );
        int offset;
        int count;
        bit split;
        bit faulted;
        logic [31:0] addr1;
        logic hit0;
        logic hit1;
        logic wr0;
        logic wr1;
        logic [2:0] frame0;
        logic [2:0] frame1;
        offset = int'(r.vAddr[3:0]);
        count = 1 << int'(r.size);
        split = (offset + count) > 16;
        addr1 = {r.vAddr[31:4], 4'h0} + 32'd16;
        {hit0, hit1, wr0, wr1, frame0, frame1} = '0;
        for (int i = 0; i < memAlignPkg::TLB_ENTRIES; i++) begin
            if (tlb[i].valid && tlb[i].vpn == r.vAddr[31:12]) begin
                hit0 = 1'b1;
                wr0 = tlb[i].writable;
                frame0 = tlb[i].frame;
            end
            if (tlb[i].valid && tlb[i].vpn == addr1[31:12]) begin
                hit1 = 1'b1;
                wr1 = tlb[i].writable;
                frame1 = tlb[i].frame;
            end
        end
        l0 = '0;
        l1 = '0;
        f = '0;
        f.tag = tagIn;
        faulted = 1'b1;
        if (!hit0) begin
            f.cause = memAlignPkg::tlbMiss;
            f.vAddr = r.vAddr;
        end else if (split && !hit1) begin
            f.cause = memAlignPkg::tlbMiss;
            f.vAddr = addr1;
        end else if (r.write && !wr0) begin
            f.cause = memAlignPkg::writeProtect;
            f.vAddr = r.vAddr;
        end else if (split && r.write && !wr1) begin
            f.cause = memAlignPkg::writeProtect;
            f.vAddr = addr1;
        end else begin
            faulted = 1'b0;
        end
        // byte placement within each line
        for (int i = 0; i < 16; i++) begin
            if (i >= offset && i - offset < 8)
                l0.data[i*8 +: 8] = r.data[(i-offset)*8 +: 8];
            if (i >= offset && i < offset + count)
                l0.byteMask[i] = 1'b1;
            if (i + 16 - offset < 8)
                l1.data[i*8 +: 8] = r.data[(i+16-offset)*8 +: 8];
            if (i < offset + count - 16)
                l1.byteMask[i] = 1'b1;
        end
        l0.lineAddr = {frame0, r.vAddr[11:4]};
        l1.lineAddr = {frame1, addr1[11:4]};
        l0.write = r.write;
        l1.write = r.write;
        l0.tag = tagIn;
        l1.tag = tagIn + 1'b1;
        return faulted ? 0 : (split ? 2 : 1);
    endfunction

    task automatic writeTlb(input int idx, input logic [19:0] vpn, input logic [2:0] frame,
                            input logic writable);
        memAlignPkg::tlbEntry_t e;
        e.valid = 1'b1;
        e.writable = writable;
        e.vpn = vpn;
        e.frame = frame;
        @(posedge clk);
        tlbWrite <= 1'b1;
        tlbIndex <= idx[2:0];
        tlbEntry <= e;
        shadowTlb[idx] = e;
        @(posedge clk);
        tlbWrite <= 1'b0;
    endtask

    task automatic runReq(input memAlignPkg::memReq_t r);
        memAlignPkg::lineReq_t l0;
        memAlignPkg::lineReq_t l1;
        memAlignPkg::faultReport_t f;
        int n;
        int busyCycles;
        n = refModel(r, shadowTlb, tbTag, l0, l1, f);
        if (n == 0) begin
            expKind.push_back(kindFault);
            expFaults.push_back(f);
        end else begin
            expKind.push_back(kindLine);
            expLines.push_back(l0);
            tbTag = tbTag + 1'b1;
            if (n == 2) begin
                expKind.push_back(kindLine);
                expLines.push_back(l1);
                tbTag = tbTag + 1'b1;
            end
        end
        @(negedge clk);
        if (busy) abortRun("busy still high before a new request");
        @(posedge clk);
        reqValid <= 1'b1;
        req <= r;
        @(posedge clk);
        reqValid <= 1'b0;
        // busy spans one cycle per line, or one cycle for a fault
        busyCycles = 0;
        do begin
            @(negedge clk);
            if (busy) busyCycles++;
        end while (busy);
        if (busyCycles != ((n == 2) ? 2 : 1)) begin
            abortRun("busy did not stay high for exactly the output pulses");
        end
        if (expKind.size() != 0) abortRun("expected pulse never appeared");
    endtask

    task automatic sendOne(input logic [31:0] addr, input logic [63:0] data,
                           input memAlignPkg::sizeCode_e size, input logic write);
        memAlignPkg::memReq_t r;
        r.vAddr = addr;
        r.data = data;
        r.size = size;
        r.write = write;
        runReq(r);
    endtask

    // pulses sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (!rst && (lineValid || faultValid)) begin
            if (lineValid && faultValid) begin
                abortRun("line and fault pulses in the same cycle");
            end else if (expKind.size() == 0) begin
                abortRun("pulse seen with no request outstanding");
            end else if (lineValid && expKind[0] != kindLine) begin
                abortRun("line pulse where a fault was expected");
            end else if (faultValid && expKind[0] != kindFault) begin
                abortRun("fault pulse where a line was expected");
            end else if (lineValid) begin
                void'(expKind.pop_front());
                checkLine(expLines.pop_front(), lineOut);
            end else begin
                void'(expKind.pop_front());
                checkFault(expFaults.pop_front(), fault);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles", cycleCount);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [19:0] pool [8];
        memAlignPkg::memReq_t r;
        logic [31:0] rnd;
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        tlbWrite = 1'b0;
        tlbIndex = '0;
        tlbEntry = '0;
        shadowTlb = '0;
        tbTag = '0;
        cycleCount = 0;
        seed = 10325;
        pool = '{20'h10, 20'h11, 20'h20, 20'h30, 20'h40, 20'h41, 20'h42, 20'h50};
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // page 0x31 stays unmapped while 0x20 and 0x41 are read only
        writeTlb(0, 20'h10, 3'd3, 1'b1);
        writeTlb(1, 20'h11, 3'd5, 1'b1);
        writeTlb(2, 20'h20, 3'd6, 1'b0);
        writeTlb(3, 20'h30, 3'd1, 1'b1);
        writeTlb(4, 20'h40, 3'd2, 1'b1);
        writeTlb(5, 20'h41, 3'd7, 1'b0);
        writeTlb(6, 20'h42, 3'd4, 1'b1);
        writeTlb(7, 20'h50, 3'd0, 1'b1);

        sendOne(32'h0001_0000, 64'h0000_0000_DDCC_BBAA, memAlignPkg::size4, 1'b0);
        sendOne(32'h0001_000C, 64'h8877_6655_4433_2211, memAlignPkg::size8, 1'b1);
        sendOne(32'h0001_0FFC, 64'h0123_4567_89AB_CDEF, memAlignPkg::size8, 1'b0);
        sendOne(32'h0009_9000, 64'h0000_0000_0000_BEEF, memAlignPkg::size2, 1'b0);
        sendOne(32'h0003_0FFE, 64'h0000_0000_CAFE_F00D, memAlignPkg::size4, 1'b0);
        sendOne(32'h0002_0100, 64'h0000_0000_1234_5678, memAlignPkg::size4, 1'b1);
        sendOne(32'h0002_0100, 64'h0000_0000_1234_5678, memAlignPkg::size4, 1'b0);

        for (int i = 0; i < randomReqs; i++) begin
            rnd = $random(seed);
            r.vAddr = {pool[rnd[2:0]], rnd[14:3]};
            // push some accesses to the end of the page
            if (rnd[15]) r.vAddr[11:4] = 8'hFF;
            r.size = memAlignPkg::sizeCode_e'(rnd[17:16]);
            r.write = rnd[18];
            r.data = {$random(seed), $random(seed)};
            runReq(r);
        end

        repeat (4) @(negedge clk);
        if (expKind.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d expected pulses left over", expKind.size());
            $display("TEST FAILED");
            $fatal(1, "leftover results");
        end
    end

endmodule

// File: build.f
memAlignPkg.sv
tlbLookup.sv
lineSplitter.sv
accessFsm.sv
requestTagCounter.sv
memAlignTop.sv
memAlignTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = memAlignTb
FILELIST = build.f
BUILDDIR = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard *.sv)

.PHONY: all run lint clean

all: run

$(BUILDDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

run: $(BUILDDIR)/V$(TOP)
	-./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
